//--- mem_system_pkg.sv
// data memory shared types
`default_nettype none

package mem_system_pkg;

    localparam int TAG_W          = 5;
    localparam int INDEX_W        = 8;
    localparam int OFFSET_W       = 3;
    localparam int WORDS_PER_LINE = 4;
    localparam int WADDR_W        = 15;  // word address, byte bit dropped
    localparam int RD_LATENCY     = 2;   // fill schedule counts on this

    typedef logic [15:0] word_t;

    // cache view of a byte address
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } cache_addr_t;

    typedef struct packed {
        logic [15:0] addr;
        word_t       data;
        logic        rd;
        logic        wr;
    } mem_req_t;

    typedef struct packed {
        logic                en;
        logic                comp;
        logic                write;
        logic                valid_in;
        logic [TAG_W-1:0]    tag_in;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
        word_t               data_in;
    } cache_cmd_t;

    typedef struct packed {
        logic             hit;
        logic             dirty;
        logic             valid;
        logic [TAG_W-1:0] tag_out;
        word_t            data_out;
    } cache_rsp_t;

    typedef enum logic [3:0] {
        idle       = 4'd0,
        rd_start   = 4'd1,
        wr_start   = 4'd2,
        evict      = 4'd3,
        evict_wait = 4'd4,
        load       = 4'd5,
        load_wait  = 4'd6,
        finish     = 4'd7,
        invalid    = 4'd15
    } ctrl_state_t;

    // power-up content of main memory
    function automatic word_t mem_init_word(input logic [WADDR_W-1:0] waddr);
        return word_t'(waddr) ^ 16'hA5C3;
    endfunction

endpackage

`default_nettype wire

//--- cache_array.sv
// direct-mapped cache storage
`default_nettype none

module cache_array (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire mem_system_pkg::cache_cmd_t cmd,
    output mem_system_pkg::cache_rsp_t      rsp
);
    import mem_system_pkg::*;

    localparam int LINES  = 1 << INDEX_W;
    localparam int WSEL_W = INDEX_W + $clog2(WORDS_PER_LINE);

    logic [TAG_W-1:0] tag_mem  [LINES];
    word_t            data_mem [LINES*WORDS_PER_LINE];
    logic [LINES-1:0] valid_q;
    logic [LINES-1:0] dirty_q;

    logic [WSEL_W-1:0] word_sel;
    logic              tag_match;
    logic              do_write;
    logic              fill_write;

    assign word_sel  = {cmd.index, cmd.offset[OFFSET_W-1:1]};  // byte bit ignored
    assign tag_match = tag_mem[cmd.index] == cmd.tag_in;

    // compare writes need a valid hit, fills always go in
    assign do_write   = cmd.en & cmd.write & (~cmd.comp | (valid_q[cmd.index] & tag_match));
    assign fill_write = cmd.en & cmd.write & ~cmd.comp;

    always_comb begin
        rsp.hit      = tag_match;
        rsp.dirty    = dirty_q[cmd.index];
        rsp.valid    = valid_q[cmd.index];
        rsp.tag_out  = tag_mem[cmd.index];
        rsp.data_out = data_mem[word_sel];
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            data_mem[word_sel] <= cmd.data_in;
        end
        if (fill_write) begin
            tag_mem[cmd.index] <= cmd.tag_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (do_write) begin
            if (cmd.comp) begin
                dirty_q[cmd.index] <= 1'b1;  // line now differs from memory
            end else begin
                valid_q[cmd.index] <= cmd.valid_in;
                dirty_q[cmd.index] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- banked_mem.sv
// four-bank word memory
`default_nettype none

module banked_mem #(
    parameter int BANK_BUSY = 4
) (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire mem_system_pkg::mem_req_t req,
    output logic                          mem_stall,
    output logic                          mem_rd_valid,
    output mem_system_pkg::word_t         mem_data
);
    import mem_system_pkg::*;

    localparam int BANKS = 4;
    localparam int ROW_W = WADDR_W - 2;
    localparam int ROWS  = 1 << ROW_W;
    localparam int CNT_W = $clog2(BANK_BUSY + 1);

    typedef struct packed {
        logic  valid;
        word_t data;
    } rd_slot_t;

    word_t            bank_mem [BANKS][ROWS];
    logic [CNT_W-1:0] busy_q   [BANKS];
    rd_slot_t         rd_pipe  [RD_LATENCY];

    logic [1:0]       bank;
    logic [ROW_W-1:0] row;
    logic             accept;

    assign bank      = req.addr[2:1];  // interleave on word address
    assign row       = req.addr[15:3];
    assign mem_stall = busy_q[bank] != '0;
    assign accept    = (req.rd | req.wr) & ~mem_stall;

    assign mem_rd_valid = rd_pipe[RD_LATENCY-1].valid;
    assign mem_data     = rd_pipe[RD_LATENCY-1].data;

    initial begin
        for (int w = 0; w < BANKS*ROWS; w++) begin
            bank_mem[w % BANKS][w / BANKS] = mem_init_word(WADDR_W'(w));
        end
    end

    always @(posedge clk) begin
        if (accept && req.wr) begin
            bank_mem[bank][row] <= req.data;
        end
    end

    // per-bank busy down-counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int b = 0; b < BANKS; b++) begin
                busy_q[b] <= '0;
            end
        end else begin
            for (int b = 0; b < BANKS; b++) begin
                if (accept && bank == 2'(b)) begin
                    busy_q[b] <= CNT_W'(BANK_BUSY);
                end else if (busy_q[b] != '0) begin
                    busy_q[b] <= busy_q[b] - 1'b1;
                end
            end
        end
    end

    // read return pipeline, one slot per cycle of latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < RD_LATENCY; i++) begin
                rd_pipe[i].valid <= 1'b0;
            end
        end else begin
            rd_pipe[0].valid <= accept & req.rd;
            rd_pipe[0].data  <= bank_mem[bank][row];
            for (int i = 1; i < RD_LATENCY; i++) begin
                rd_pipe[i] <= rd_pipe[i-1];
            end
        end
    end

endmodule

`default_nettype wire

//--- cache_ctrl.sv
// cache miss controller
`default_nettype none

module cache_ctrl (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire mem_system_pkg::word_t      addr,
    input  wire mem_system_pkg::word_t      data_in,
    input  wire                             rd,
    input  wire                             wr,
    output mem_system_pkg::word_t           data_out,
    output logic                            done,
    output logic                            stall,
    output logic                            cache_hit,
    output logic                            err,
    output mem_system_pkg::cache_cmd_t      cmd,
    input  wire mem_system_pkg::cache_rsp_t rsp,
    output mem_system_pkg::mem_req_t        req,
    input  wire                             mem_stall,
    input  wire                             mem_rd_valid,
    input  wire mem_system_pkg::word_t      mem_data
);
    import mem_system_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;
    cache_addr_t pa;
    logic [1:0]  issue_cnt;  // next word to send to memory
    logic [1:0]  ret_cnt;    // next fill word coming back
    logic        is_wr;
    logic        err_q;
    logic        req_bad;
    logic        line_hit;
    logic        mem_accept;

    assign pa         = addr;
    assign req_bad    = pa.offset[0] | (rd & wr);
    assign line_hit   = rsp.hit & rsp.valid;
    assign mem_accept = (req.rd | req.wr) & ~mem_stall;
    assign data_out   = rsp.data_out;
    assign stall      = state != idle;

    always_comb begin
        next_state = invalid;
        done       = 1'b0;
        cache_hit  = 1'b0;
        err        = err_q;

        cmd.en       = 1'b0;
        cmd.comp     = 1'b0;
        cmd.write    = 1'b0;
        cmd.valid_in = 1'b1;
        cmd.tag_in   = pa.tag;
        cmd.index    = pa.index;
        cmd.offset   = pa.offset;
        cmd.data_in  = data_in;

        req.addr = {pa.tag, pa.index, issue_cnt, 1'b0};  // fill word address
        req.data = '0;
        req.rd   = 1'b0;
        req.wr   = 1'b0;

        // reads are only in flight during the load states
        if (mem_rd_valid) begin
            cmd.en      = 1'b1;
            cmd.write   = 1'b1;
            cmd.offset  = {ret_cnt, 1'b0};
            cmd.data_in = mem_data;
        end

        case (state)
            idle: begin
                if (rd | wr) begin
                    next_state = req_bad ? finish : (wr ? wr_start : rd_start);
                end else begin
                    next_state = idle;
                end
            end
            rd_start, wr_start: begin
                cmd.en     = 1'b1;
                cmd.comp   = 1'b1;
                cmd.write  = state == wr_start;
                done       = line_hit;
                cache_hit  = line_hit;
                if (line_hit) begin
                    next_state = idle;
                end else if (rsp.valid & rsp.dirty) begin
                    next_state = evict;
                end else begin
                    next_state = load;
                end
            end
            evict: begin
                cmd.en     = 1'b1;
                cmd.offset = {issue_cnt, 1'b0};
                req.addr   = {rsp.tag_out, pa.index, issue_cnt, 1'b0};  // old line home
                req.data   = rsp.data_out;
                req.wr     = 1'b1;
                next_state = (mem_accept && issue_cnt == 2'd3) ? evict_wait : evict;
            end
            evict_wait: begin
                next_state = mem_stall ? evict_wait : load;  // wait on bank of fill word 0
            end
            load: begin
                req.rd     = 1'b1;
                next_state = (mem_accept && issue_cnt == 2'd3) ? load_wait : load;
            end
            load_wait: begin
                next_state = (mem_rd_valid && ret_cnt == 2'd3) ? finish : load_wait;
            end
            finish: begin
                done = 1'b1;
                if (!err_q) begin
                    cmd.en    = 1'b1;  // line is present now
                    cmd.comp  = 1'b1;
                    cmd.write = is_wr;
                end
                next_state = idle;
            end
            invalid: begin
                err        = 1'b1;
                next_state = idle;
            end
            default: next_state = invalid;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= idle;
            issue_cnt <= '0;
            ret_cnt   <= '0;
            is_wr     <= 1'b0;
            err_q     <= 1'b0;
        end else begin
            state <= next_state;
            err_q <= (state == idle) & (rd | wr) & req_bad;
            if (state == idle) begin
                issue_cnt <= '0;
                ret_cnt   <= '0;
                is_wr     <= wr;
            end else begin
                if (mem_accept) begin
                    issue_cnt <= issue_cnt + 2'd1;
                end
                if (mem_rd_valid) begin
                    ret_cnt <= ret_cnt + 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- mem_system.sv
// data memory subsystem top
`default_nettype none

module mem_system #(
    parameter int BANK_BUSY = 4
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire mem_system_pkg::word_t addr,
    input  wire mem_system_pkg::word_t data_in,
    input  wire                        rd,
    input  wire                        wr,
    output mem_system_pkg::word_t      data_out,
    output logic                       done,
    output logic                       stall,
    output logic                       cache_hit,
    output logic                       err
);
    import mem_system_pkg::*;

    cache_cmd_t cmd;
    cache_rsp_t rsp;
    mem_req_t   req;
    logic       mem_stall;
    logic       mem_rd_valid;
    word_t      mem_data;

    cache_ctrl i_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .addr         (addr),
        .data_in      (data_in),
        .rd           (rd),
        .wr           (wr),
        .data_out     (data_out),
        .done         (done),
        .stall        (stall),
        .cache_hit    (cache_hit),
        .err          (err),
        .cmd          (cmd),
        .rsp          (rsp),
        .req          (req),
        .mem_stall    (mem_stall),
        .mem_rd_valid (mem_rd_valid),
        .mem_data     (mem_data)
    );

    cache_array i_cache (
        .clk   (clk),
        .rst_n (rst_n),
        .cmd   (cmd),
        .rsp   (rsp)
    );

    banked_mem #(
        .BANK_BUSY (BANK_BUSY)
    ) i_mem (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .mem_stall    (mem_stall),
        .mem_rd_valid (mem_rd_valid),
        .mem_data     (mem_data)
    );

endmodule

`default_nettype wire

//--- mem_system_sva.sv
// controller handshake assertions
`default_nettype none

module mem_system_sva (
    input wire                              clk,
    input wire                              rst_n,
    input wire mem_system_pkg::ctrl_state_t state,
    input wire                              rd,
    input wire                              wr,
    input wire                              stall,
    input wire                              done,
    input wire mem_system_pkg::mem_req_t    req,
    input wire                              mem_stall
);
    import mem_system_pkg::*;

    int fail_cnt = 0;  // failure tally

    // a request is taken exactly when stall is low
    accept_rule: assert property (@(posedge clk) disable iff (!rst_n)
        !stall |=> stall == $past(rd | wr))
        else begin
            $error("stall did not follow the request rule");
            fail_cnt++;
        end

    done_to_idle: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> state == idle)
        else begin
            $error("controller not idle after done");
            fail_cnt++;
        end

    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else begin
            $error("done held for more than one cycle");
            fail_cnt++;
        end

    // a stalled memory request must not move
    req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (req.rd | req.wr) && mem_stall |=> $stable(req))
        else begin
            $error("memory request changed while the bank stalled");
            fail_cnt++;
        end

endmodule

`default_nettype wire

//--- tb_mem_system.sv
// data memory subsystem testbench
`default_nettype none

module tb_mem_system;
    import mem_system_pkg::*;

    localparam int CLK_PERIOD    = 20;
    localparam int DRIVE_DLY     = 2;
    localparam int RST_CYCLES    = 10;
    localparam int N_DIRECTED    = 11;
    localparam int N_RAND        = 200;
    localparam int N_OPS         = N_DIRECTED + N_RAND;
    localparam int WATCHDOG_TIME = (N_OPS * 40 + RST_CYCLES) * CLK_PERIOD;

    typedef struct packed {
        word_t data;
        logic  hit;
        logic  err;
        logic  chk_data;  // writes return nothing worth checking
    } expect_t;

    logic  clk;
    logic  rst_n;
    word_t addr;
    word_t data_in;
    logic  rd;
    logic  wr;
    word_t data_out;
    logic  done;
    logic  stall;
    logic  cache_hit;
    logic  err;

    word_t                shadow_mem [1 << WADDR_W];
    logic [TAG_W-1:0]     shadow_tag [1 << INDEX_W];
    logic [(1 << INDEX_W)-1:0] shadow_valid;
    logic [15:0]          lfsr_q;
    expect_t              exp_q [$];
    string                name_q [$];
    expect_t              cur_exp;
    string                cur_name;
    int                   value_errs;
    int                   other_errs;
    int                   checks;

    mem_system #(
        .BANK_BUSY (10)  // banks still busy when the next miss starts
    ) i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .addr      (addr),
        .data_in   (data_in),
        .rd        (rd),
        .wr        (wr),
        .data_out  (data_out),
        .done      (done),
        .stall     (stall),
        .cache_hit (cache_hit),
        .err       (err)
    );

    bind cache_ctrl mem_system_sva i_sva (
        .clk       (clk),
        .rst_n     (rst_n),
        .state     (state),
        .rd        (rd),
        .wr        (wr),
        .stall     (stall),
        .done      (done),
        .req       (req),
        .mem_stall (mem_stall)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // power-up memory content, word address xor constant
    function automatic word_t init_word(input int waddr);
        return word_t'(waddr) ^ 16'hA5C3;
    endfunction

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v      = {v[14:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
        return v;
    endfunction

    // flat view of memory plus a tag table decides data and hit
    function automatic expect_t model_access(input word_t a, input word_t d,
                                             input logic is_rd, input logic is_wr);
        expect_t     e;
        cache_addr_t ca;
        ca = a;
        e  = '0;
        if (a[0] || (is_rd && is_wr)) begin
            e.err = 1'b1;
            return e;
        end
        e.hit = shadow_valid[ca.index] && (shadow_tag[ca.index] == ca.tag);
        shadow_valid[ca.index] = 1'b1;
        shadow_tag[ca.index]   = ca.tag;
        if (is_wr) begin
            shadow_mem[a[15:1]] = d;
        end else begin
            e.data     = shadow_mem[a[15:1]];
            e.chk_data = 1'b1;
        end
        return e;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
            value_errs++;
        end
    endtask

    // entered DRIVE_DLY after a rising edge with the DUT idle
    task automatic run_access(input string name, input word_t a, input word_t d,
                              input logic r, input logic w);
        expect_t e;
        e = model_access(a, d, r, w);
        exp_q.push_back(e);
        name_q.push_back(name);
        if (stall) begin
            $display("stall was high when %s was issued", name);
            other_errs++;
        end
        addr    = a;
        data_in = d;
        rd      = r;
        wr      = w;
        @(posedge clk);  // accepted here
        #DRIVE_DLY;
        rd = 1'b0;
        wr = 1'b0;
        @(negedge clk);
        while (!done) @(negedge clk);
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic run_random(input int n);
        logic [1:0] t;
        logic [1:0] ix;
        logic [1:0] wd;
        word_t      d;
        logic       w;
        t  = 2'(rand_bits(2));  // small tag and index range forces evictions
        ix = 2'(rand_bits(2));
        wd = 2'(rand_bits(2));
        d  = rand_bits(16);
        w  = 1'(rand_bits(1));
        run_access($sformatf("rand_%0d", n), {3'b000, t, 6'b0, ix, wd, 1'b0}, d, ~w, w);
    endtask

    // compare process
    initial begin
        forever begin
            @(negedge clk);
            if (rst_n && done) begin
                if (exp_q.size() == 0) begin
                    $display("done was raised with no request outstanding");
                    other_errs++;
                end else begin
                    cur_exp  = exp_q.pop_front();
                    cur_name = name_q.pop_front();
                    if (cur_exp.chk_data) begin
                        check_word({cur_name, " data"}, cur_exp.data, data_out);
                    end
                    check_flag({cur_name, " hit"}, cur_exp.hit, cache_hit);
                    check_flag({cur_name, " err"}, cur_exp.err, err);
                end
            end
        end
    end

    initial begin
        #WATCHDOG_TIME;
        $display("timeout, the run did not finish within %0d time units", WATCHDOG_TIME);
        $display("Verification failed");
        $finish;
    end

    initial begin
        rst_n        = 1'b0;
        addr         = '0;
        data_in      = '0;
        rd           = 1'b0;
        wr           = 1'b0;
        value_errs   = 0;
        other_errs   = 0;
        checks       = 0;
        lfsr_q       = 16'd63870;
        shadow_valid = '0;
        for (int w = 0; w < (1 << WADDR_W); w++) begin
            shadow_mem[w] = init_word(w);
        end

        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        @(negedge clk);
        check_flag("reset done", 1'b0, done);
        check_flag("reset hit", 1'b0, cache_hit);
        check_flag("reset err", 1'b0, err);
        check_flag("reset stall", 1'b0, stall);
        @(posedge clk);
        #DRIVE_DLY;

        run_access("first_read", 16'h1234, '0, 1'b1, 1'b0);
        run_access("repeat_read", 16'h1234, '0, 1'b1, 1'b0);
        run_access("write_hit", 16'h1234, 16'hBEEF, 1'b0, 1'b1);
        run_access("read_after_write", 16'h1234, '0, 1'b1, 1'b0);
        run_access("write_before_evict", 16'h1234, 16'h5A17, 1'b0, 1'b1);
        run_access("evict_read", 16'h1234 ^ 16'h0800, '0, 1'b1, 1'b0);  // same index
        run_access("reload_read", 16'h1234, '0, 1'b1, 1'b0);
        run_access("line_neighbour", 16'h1236, '0, 1'b1, 1'b0);
        run_access("odd_addr", 16'h1235, 16'h0BAD, 1'b0, 1'b1);
        run_access("rd_wr_both", 16'h1234, 16'h0BAD, 1'b1, 1'b1);
        run_access("after_err_read", 16'h1234, '0, 1'b1, 1'b0);

        for (int i = 0; i < N_RAND; i++) begin
            run_random(i);
        end

        repeat (4) @(posedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d requests never saw done", exp_q.size());
            other_errs++;
        end
        $display("checks %0d, value errors %0d, other errors %0d, assertion failures %0d",
                 checks, value_errs, other_errs, i_dut.i_ctrl.i_sva.fail_cnt);
        if (value_errs + other_errs + i_dut.i_ctrl.i_sva.fail_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mem_system.f
mem_system_pkg.sv
cache_array.sv
banked_mem.sv
cache_ctrl.sv
mem_system.sv
mem_system_sva.sv
tb_mem_system.sv
